// File: src/dmb_defines.svh
`ifndef DMB_DEFINES_SVH
`define DMB_DEFINES_SVH

////////////////////////////////////////////////////////////
// Widths
////////////////////////////////////////////////////////////

`define DMB_NCFEB        5
`define DMB_CMD_W        6
`define DMB_DATA_W       8
`define DMB_LCT_TMR_W    10
`define DMB_DAV_TMR_W    6

////////////////////////////////////////////////////////////
// CCB command codes and cycle counts
////////////////////////////////////////////////////////////

`define DMB_CMD_SET_CFG  6'h30
`define DMB_CMD_L1A_RST  6'h03
// Calibration codes run CAL0, CAL0+1, CAL0+2
`define DMB_CMD_TTC_CAL0 6'h14

`define DMB_FPGA_RST_CYC 16
`define DMB_CRDY_CYC     24
`define DMB_HOLDOFF_CYC  256

`endif

// File: src/dmb_pkg.sv
`include "dmb_defines.svh"

package dmb_pkg;

	// One bit per CFEB
	typedef logic [`DMB_NCFEB-1:0]  cfeb_vec_t;

	// CCB bus fields
	typedef logic [`DMB_CMD_W-1:0]  ccb_cmd_t;
	typedef logic [`DMB_DATA_W-1:0] ccb_data_t;

	// Calibration lines, bit 2 pedestal, bit 1 inject, bit 0 pulse
	typedef logic [2:0]             cal_vec_t;

	typedef enum logic [1:0]
	{
		RST_IDLE,
		RST_PULSE,
		RST_WAIT_READY,
		RST_DONE
	} rst_state_t;

	typedef enum logic
	{
		TMR_IDLE,
		TMR_RUN
	} tmr_state_t;

endpackage

// File: src/dmb_cfg_if.sv
`timescale 1ns/1ps

interface dmb_cfg_if;

	logic encode_en;
	logic cable_dly;
	logic cal_trg_sel;
	logic pls_gate_en;

	// Command decoder owns the configuration register
	modport dec
	(
		output encode_en,
		output cable_dly,
		output cal_trg_sel,
		output pls_gate_en
	);

	modport user
	(
		input encode_en,
		input cable_dly,
		input cal_trg_sel,
		input pls_gate_en
	);

endinterface

// File: src/ccb_cmd_dec.sv
`timescale 1ns/1ps
`include "dmb_defines.svh"

module ccb_cmd_dec
(
	input  logic               clkcms,
	input  logic               clr0,
	input  logic               ccb_cmd_strb_i,
	input  dmb_pkg::ccb_cmd_t  ccb_cmd_i,
	input  dmb_pkg::ccb_data_t ccb_data_i,
	dmb_cfg_if.dec             cfg,
	output logic               l1a_srst_o,
	output dmb_pkg::cal_vec_t  ttc_cal_o
);

	logic              set_cfg;
	logic              l1a_rst;
	dmb_pkg::cal_vec_t ttc_hit;

	assign set_cfg = ccb_cmd_strb_i && (ccb_cmd_i == `DMB_CMD_SET_CFG);
	assign l1a_rst = ccb_cmd_strb_i && (ccb_cmd_i == `DMB_CMD_L1A_RST);

	// Three consecutive codes, one per calibration line
	always_comb
	begin
		for (int k = 0; k < 3; k++)
			ttc_hit[k] = ccb_cmd_strb_i &&
				(ccb_cmd_i == dmb_pkg::ccb_cmd_t'(`DMB_CMD_TTC_CAL0 + k));
	end

	// One-cycle strobes
	always_ff @(posedge clkcms or posedge clr0)
	begin
		if (clr0)
		begin
			l1a_srst_o <= 1'b0;
			ttc_cal_o  <= '0;
		end
		else
		begin
			l1a_srst_o <= l1a_rst;
			ttc_cal_o  <= ttc_hit;
		end
	end

	// Configuration register, soft reset wins over a write
	always_ff @(posedge clkcms or posedge clr0)
	begin
		if (clr0 || l1a_srst_o)
		begin
			cfg.encode_en   <= 1'b0;
			cfg.cable_dly   <= 1'b0;
			cfg.cal_trg_sel <= 1'b0;
			cfg.pls_gate_en <= 1'b0;
		end
		else if (set_cfg)
		begin
			cfg.encode_en   <= ccb_data_i[0];
			cfg.cable_dly   <= ccb_data_i[1];
			cfg.cal_trg_sel <= ccb_data_i[2];
			cfg.pls_gate_en <= ccb_data_i[3];
		end
	end

	a_srst_cal_excl: assert property (@(posedge clkcms) disable iff (clr0)
		!(l1a_srst_o && (|ttc_cal_o)));

endmodule

// File: src/reset_seq.sv
`timescale 1ns/1ps
`include "dmb_defines.svh"

module reset_seq
(
	input  logic clkcms,
	input  logic clr0,
	input  logic fpga_ready_i,
	input  logic reset_i,
	input  logic l1a_srst_i,
	output logic fpga_rst_o,
	output logic rst_o,
	output logic holdoff_o,
	output logic ctrl_ready_o
);

	localparam int CNT_W = $clog2(`DMB_CRDY_CYC);
	localparam int HO_W  = $clog2(`DMB_HOLDOFF_CYC);

	logic                rdy_meta;
	logic                rdy_sync;
	logic                rdy_sync_q;
	logic                rdy_rise;
	logic                ready_clr;
	logic                crdy_hit;
	logic [CNT_W-1:0]    seq_cnt;
	logic [HO_W-1:0]     ho_cnt;
	dmb_pkg::rst_state_t state;

	////////////////////////////////////////////////////////////
	// Ready synchronizer and edge detect
	////////////////////////////////////////////////////////////

	always_ff @(posedge clkcms or posedge clr0)
	begin
		if (clr0)
		begin
			rdy_meta   <= 1'b0;
			rdy_sync   <= 1'b0;
			rdy_sync_q <= 1'b0;
		end
		else
		begin
			rdy_meta   <= fpga_ready_i;
			rdy_sync   <= rdy_meta;
			rdy_sync_q <= rdy_sync;
		end
	end

	assign rdy_rise = rdy_sync & ~rdy_sync_q;

	////////////////////////////////////////////////////////////
	// Sequencer, one counter for pulse and ready delay
	////////////////////////////////////////////////////////////

	always_ff @(posedge clkcms or posedge clr0)
	begin
		if (clr0)
		begin
			state   <= dmb_pkg::RST_IDLE;
			seq_cnt <= '0;
		end
		else if (!rdy_sync)
		begin
			state   <= dmb_pkg::RST_IDLE;
			seq_cnt <= '0;
		end
		else
		begin
			case (state)
				dmb_pkg::RST_IDLE:
				begin
					seq_cnt <= '0;
					if (rdy_rise)
						state <= dmb_pkg::RST_PULSE;
				end
				dmb_pkg::RST_PULSE:
				begin
					seq_cnt <= seq_cnt + 1'b1;
					if (seq_cnt == CNT_W'(`DMB_FPGA_RST_CYC - 1))
						state <= dmb_pkg::RST_WAIT_READY;
				end
				dmb_pkg::RST_WAIT_READY:
				begin
					seq_cnt <= seq_cnt + 1'b1;
					if (crdy_hit)
						state <= dmb_pkg::RST_DONE;
				end
				default:
					state <= dmb_pkg::RST_DONE;
			endcase
		end
	end

	assign fpga_rst_o = (state == dmb_pkg::RST_PULSE);
	assign crdy_hit   = (state == dmb_pkg::RST_WAIT_READY) &&
		(seq_cnt == CNT_W'(`DMB_CRDY_CYC - 1));
	assign rst_o      = reset_i | fpga_rst_o | l1a_srst_i;

	// Drops straight away when the board ready goes low
	assign ready_clr = clr0 | ~fpga_ready_i;

	always_ff @(posedge clkcms or posedge ready_clr)
	begin
		if (ready_clr)
			ctrl_ready_o <= 1'b0;
		else if (crdy_hit)
			ctrl_ready_o <= 1'b1;
	end

	// Power-on holdoff for the interval timers
	always_ff @(posedge clkcms or posedge clr0)
	begin
		if (clr0)
		begin
			holdoff_o <= 1'b0;
			ho_cnt    <= '0;
		end
		else if (fpga_rst_o || (state == dmb_pkg::RST_IDLE && rdy_rise))
		begin
			holdoff_o <= 1'b1;
			ho_cnt    <= '0;
		end
		else if (holdoff_o)
		begin
			if (ho_cnt == HO_W'(`DMB_HOLDOFF_CYC - 1))
				holdoff_o <= 1'b0;
			ho_cnt <= ho_cnt + 1'b1;
		end
	end

	a_ready_not_in_rst: assert property (@(posedge clkcms) disable iff (clr0)
		!(ctrl_ready_o && fpga_rst_o));

endmodule

// File: src/cal_pulse_cond.sv
`timescale 1ns/1ps

module cal_pulse_cond
(
	input  logic              clkcms,
	input  logic              clr0,
	input  logic              rst_i,
	input  dmb_pkg::cal_vec_t ccb_cal_b_i,
	input  dmb_pkg::cal_vec_t ttc_cal_i,
	dmb_cfg_if.user           cfg,
	output logic              pedestal_o,
	output logic              inject_o,
	output logic              pulse_o
);

	dmb_pkg::cal_vec_t cal_in;
	logic              inj_1;
	logic              pls_1;
	logic              pls_2;
	logic              rst_q;
	logic              pls_toggle;
	logic              gate_on;

	// Active-low CCB lines merged with TTC pulses
	assign cal_in  = ~ccb_cal_b_i | ttc_cal_i;
	assign gate_on = cfg.pls_gate_en & cfg.cal_trg_sel;

	// Alternating enable, restarts on each new reset
	always_ff @(posedge clkcms or posedge clr0)
	begin
		if (clr0)
		begin
			rst_q      <= 1'b0;
			pls_toggle <= 1'b0;
		end
		else
		begin
			rst_q      <= rst_i;
			pls_toggle <= (rst_i & ~rst_q) ? 1'b0 : ~pls_toggle;
		end
	end

	always_ff @(posedge clkcms or posedge clr0)
	begin
		if (clr0)
		begin
			pedestal_o <= 1'b0;
			inj_1      <= 1'b0;
			inject_o   <= 1'b0;
			pls_1      <= 1'b0;
			pls_2      <= 1'b0;
			pulse_o    <= 1'b0;
		end
		else
		begin
			pedestal_o <= cal_in[2];
			inj_1      <= cal_in[1];
			inject_o   <= inj_1;
			pls_1      <= cal_in[0];
			pls_2      <= pls_1;
			// Stretched by one cycle
			pulse_o    <= (pls_1 | pls_2) & (pls_toggle | ~gate_on);
		end
	end

endmodule

// File: src/trg_timer.sv
`timescale 1ns/1ps

module trg_timer #(
	parameter int W = 10
)
(
	input  logic         clkcms,
	input  logic         clr0,
	input  logic         holdoff_i,
	input  logic         clr_i,
	input  logic         start_i,
	input  logic         stop_i,
	output logic [W-1:0] time_o
);

	dmb_pkg::tmr_state_t state;
	logic [W-1:0]        cnt;
	logic [W-1:0]        cnt_inc;

	// Saturating increment
	assign cnt_inc = (cnt == '1) ? cnt : cnt + 1'b1;

	always_ff @(posedge clkcms or posedge clr0)
	begin
		if (clr0)
		begin
			state  <= dmb_pkg::TMR_IDLE;
			cnt    <= '0;
			time_o <= '0;
		end
		else
		begin
			case (state)
				dmb_pkg::TMR_IDLE:
				begin
					if (start_i && !holdoff_i)
					begin
						state <= dmb_pkg::TMR_RUN;
						cnt   <= '0;
					end
				end
				default:
				begin
					if (holdoff_i)
						state <= dmb_pkg::TMR_IDLE;
					else if (stop_i)
						state <= dmb_pkg::TMR_IDLE;
					cnt <= cnt_inc;
				end
			endcase
			if (clr_i)
				time_o <= '0;
			else if (state == dmb_pkg::TMR_RUN && stop_i && !holdoff_i)
				time_o <= cnt_inc;
		end
	end

	a_no_wrap: assert property (@(posedge clkcms) disable iff (clr0)
		(state == dmb_pkg::TMR_RUN && cnt == '1) |=>
		(state != dmb_pkg::TMR_RUN || cnt == '1));

endmodule

// File: src/trg_enc_out.sv
`timescale 1ns/1ps
`include "dmb_defines.svh"

module trg_enc_out
(
	input  logic               clkcms,
	input  logic               clr0,
	input  logic               fpga_rst_i,
	input  dmb_pkg::cfeb_vec_t pre_lct_i,
	input  dmb_pkg::cfeb_vec_t l1a_match_i,
	input  logic               l1a_cfeb_i,
	dmb_cfg_if.user            cfg,
	output dmb_pkg::cfeb_vec_t trg_enc_b0_o,
	output dmb_pkg::cfeb_vec_t trg_enc_b1_o,
	output dmb_pkg::cfeb_vec_t trg_enc_b2_o
);

	dmb_pkg::cfeb_vec_t enc_b0;
	dmb_pkg::cfeb_vec_t enc_b1;
	dmb_pkg::cfeb_vec_t enc_b2;
	dmb_pkg::cfeb_vec_t enc_b0_d;
	dmb_pkg::cfeb_vec_t enc_b1_d;
	dmb_pkg::cfeb_vec_t enc_b2_d;

	////////////////////////////////////////////////////////////
	// Per-CFEB encoding
	////////////////////////////////////////////////////////////

	assign enc_b0 = pre_lct_i;
	assign enc_b1 = l1a_match_i;
	assign enc_b2 = cfg.encode_en ? {`DMB_NCFEB{l1a_cfeb_i}} : '0;

	// Cable delay stage
	always_ff @(posedge clkcms)
	begin
		enc_b0_d <= enc_b0;
		enc_b1_d <= enc_b1;
		enc_b2_d <= enc_b2;
	end

	always_ff @(posedge clkcms or posedge clr0)
	begin
		if (clr0)
		begin
			trg_enc_b0_o <= '0;
			trg_enc_b1_o <= '0;
			trg_enc_b2_o <= '0;
		end
		else if (fpga_rst_i)
		begin
			trg_enc_b0_o <= '0;
			trg_enc_b1_o <= '0;
			trg_enc_b2_o <= '0;
		end
		else
		begin
			trg_enc_b0_o <= cfg.cable_dly ? enc_b0_d : enc_b0;
			trg_enc_b1_o <= cfg.cable_dly ? enc_b1_d : enc_b1;
			trg_enc_b2_o <= cfg.cable_dly ? enc_b2_d : enc_b2;
		end
	end

	a_quiet_in_rst: assert property (@(posedge clkcms) disable iff (clr0)
		fpga_rst_i |=> (trg_enc_b0_o == '0 && trg_enc_b1_o == '0 &&
		trg_enc_b2_o == '0));

endmodule

// File: src/dmb_trig_ctrl.sv
`timescale 1ns/1ps
`include "dmb_defines.svh"

module dmb_trig_ctrl
(
	input  logic                     clkcms,
	input  logic                     clr0,
	input  logic                     fpga_ready_i,
	input  logic                     reset_i,
	input  logic                     ccb_cmd_strb_i,
	input  dmb_pkg::ccb_cmd_t        ccb_cmd_i,
	input  dmb_pkg::ccb_data_t       ccb_data_i,
	input  dmb_pkg::cal_vec_t        ccb_cal_b_i,
	input  dmb_pkg::cfeb_vec_t       pre_lct_i,
	input  dmb_pkg::cfeb_vec_t       l1a_match_i,
	input  logic                     l1a_cfeb_i,
	input  logic                     l1acc_i,
	input  logic                     dav_i,
	input  logic                     tmr_clr_i,
	output logic                     ctrl_ready_o,
	output logic                     l1a_srst_o,
	output logic                     pedestal_o,
	output logic                     inject_o,
	output logic                     pulse_o,
	output dmb_pkg::cfeb_vec_t       trg_enc_b0_o,
	output dmb_pkg::cfeb_vec_t       trg_enc_b1_o,
	output dmb_pkg::cfeb_vec_t       trg_enc_b2_o,
	output logic [`DMB_LCT_TMR_W-1:0] lct_l1a_time_o,
	output logic [`DMB_DAV_TMR_W-1:0] l1a_dav_time_o
);

	dmb_cfg_if         cfg_bus ();
	dmb_pkg::cal_vec_t ttc_cal;
	logic              fpga_rst;
	logic              comb_rst;
	logic              holdoff;

	ccb_cmd_dec u_ccb_cmd_dec (
		.clkcms         (clkcms),
		.clr0           (clr0),
		.ccb_cmd_strb_i (ccb_cmd_strb_i),
		.ccb_cmd_i      (ccb_cmd_i),
		.ccb_data_i     (ccb_data_i),
		.cfg            (cfg_bus),
		.l1a_srst_o     (l1a_srst_o),
		.ttc_cal_o      (ttc_cal)
	);

	reset_seq u_reset_seq (
		.clkcms       (clkcms),
		.clr0         (clr0),
		.fpga_ready_i (fpga_ready_i),
		.reset_i      (reset_i),
		.l1a_srst_i   (l1a_srst_o),
		.fpga_rst_o   (fpga_rst),
		.rst_o        (comb_rst),
		.holdoff_o    (holdoff),
		.ctrl_ready_o (ctrl_ready_o)
	);

	cal_pulse_cond u_cal_pulse_cond (
		.clkcms      (clkcms),
		.clr0        (clr0),
		.rst_i       (comb_rst),
		.ccb_cal_b_i (ccb_cal_b_i),
		.ttc_cal_i   (ttc_cal),
		.cfg         (cfg_bus),
		.pedestal_o  (pedestal_o),
		.inject_o    (inject_o),
		.pulse_o     (pulse_o)
	);

	trg_enc_out u_trg_enc_out (
		.clkcms       (clkcms),
		.clr0         (clr0),
		.fpga_rst_i   (fpga_rst),
		.pre_lct_i    (pre_lct_i),
		.l1a_match_i  (l1a_match_i),
		.l1a_cfeb_i   (l1a_cfeb_i),
		.cfg          (cfg_bus),
		.trg_enc_b0_o (trg_enc_b0_o),
		.trg_enc_b1_o (trg_enc_b1_o),
		.trg_enc_b2_o (trg_enc_b2_o)
	);

	// Any CFEB LCT starts the LCT-to-L1A interval
	trg_timer #(.W(`DMB_LCT_TMR_W)) u_lct_l1a_tmr (
		.clkcms    (clkcms),
		.clr0      (clr0),
		.holdoff_i (holdoff),
		.clr_i     (tmr_clr_i),
		.start_i   (|pre_lct_i),
		.stop_i    (l1acc_i),
		.time_o    (lct_l1a_time_o)
	);

	trg_timer #(.W(`DMB_DAV_TMR_W)) u_l1a_dav_tmr (
		.clkcms    (clkcms),
		.clr0      (clr0),
		.holdoff_i (holdoff),
		.clr_i     (tmr_clr_i),
		.start_i   (l1acc_i),
		.stop_i    (dav_i),
		.time_o    (l1a_dav_time_o)
	);

endmodule

// File: sim/tb_dmb_trig_ctrl.sv
`timescale 1ns/1ps
`include "dmb_defines.svh"

module tb_dmb_trig_ctrl;

	localparam int READY_TIMEOUT   = 200;
	localparam int HOLDOFF_TIMEOUT = 2000;
	localparam int RESULT_TIMEOUT  = 20;
	localparam int MAX_RECORDS     = 64;

	logic                      clkcms;
	logic                      clr0;
	logic                      fpga_ready_i;
	logic                      reset_i;
	logic                      ccb_cmd_strb_i;
	dmb_pkg::ccb_cmd_t         ccb_cmd_i;
	dmb_pkg::ccb_data_t        ccb_data_i;
	dmb_pkg::cal_vec_t         ccb_cal_b_i;
	dmb_pkg::cfeb_vec_t        pre_lct_i;
	dmb_pkg::cfeb_vec_t        l1a_match_i;
	logic                      l1a_cfeb_i;
	logic                      l1acc_i;
	logic                      dav_i;
	logic                      tmr_clr_i;
	logic                      ctrl_ready_o;
	logic                      l1a_srst_o;
	logic                      pedestal_o;
	logic                      inject_o;
	logic                      pulse_o;
	dmb_pkg::cfeb_vec_t        trg_enc_b0_o;
	dmb_pkg::cfeb_vec_t        trg_enc_b1_o;
	dmb_pkg::cfeb_vec_t        trg_enc_b2_o;
	logic [`DMB_LCT_TMR_W-1:0] lct_l1a_time_o;
	logic [`DMB_DAV_TMR_W-1:0] l1a_dav_time_o;

	logic [31:0]        vec_mem [0:MAX_RECORDS-1];
	dmb_pkg::cfeb_vec_t exp_b0 [0:255];
	dmb_pkg::cfeb_vec_t exp_b1 [0:255];
	dmb_pkg::cfeb_vec_t exp_b2 [0:255];
	logic               enc_en_exp;
	int                 value_errs;
	int                 other_errs;

	dmb_trig_ctrl DUT (.*);

	initial
	begin
		clkcms = 1'b0;
		forever #20 clkcms = ~clkcms;
	end

	task automatic flag_mismatch(string name, int exp_val, int act_val);
		value_errs++;
		$display("ERR %0t %s expected %0h actual %0h", $time, name, exp_val, act_val);
	endtask

	task automatic note_failure(string msg);
		other_errs++;
		$display("FAILURE at %0t: %s", $time, msg);
	endtask

	////////////////////////////////////////////////////////////
	// Reset sequence after the board ready rises
	////////////////////////////////////////////////////////////

	task automatic check_reset_sequence();
		int idx       = 0;
		int first_rst = -1;
		int rst_len   = 0;
		int ready_idx = -1;
		@(negedge clkcms);
		fpga_ready_i = 1'b1;
		while (ready_idx < 0 && idx < READY_TIMEOUT)
		begin
			@(negedge clkcms);
			if (DUT.fpga_rst)
			begin
				if (first_rst < 0)
					first_rst = idx;
				rst_len++;
			end
			if (ctrl_ready_o)
				ready_idx = idx;
			idx++;
		end
		if (ready_idx < 0)
			note_failure("ctrl_ready_o did not rise after fpga_ready_i went high");
		else if (first_rst < 0)
			note_failure("FPGA reset never pulsed after fpga_ready_i went high");
		else
		begin
			if (rst_len != `DMB_FPGA_RST_CYC)
				flag_mismatch("fpga_rst cycles", `DMB_FPGA_RST_CYC, rst_len);
			if (ready_idx - first_rst != `DMB_CRDY_CYC)
				flag_mismatch("ctrl_ready_o delay", `DMB_CRDY_CYC, ready_idx - first_rst);
		end
	endtask

	task automatic send_command(int cmd, int data, int exp_srst);
		int pulses = 0;
		@(negedge clkcms);
		ccb_cmd_strb_i = 1'b1;
		ccb_cmd_i      = dmb_pkg::ccb_cmd_t'(cmd);
		ccb_data_i     = dmb_pkg::ccb_data_t'(data);
		@(negedge clkcms);
		ccb_cmd_strb_i = 1'b0;
		// Encode mode sits in data bit 0, soft reset clears it
		if (cmd == int'(`DMB_CMD_SET_CFG))
			enc_en_exp = data[0];
		else if (cmd == int'(`DMB_CMD_L1A_RST))
			enc_en_exp = 1'b0;
		repeat (4)
		begin
			if (l1a_srst_o)
				pulses++;
			@(negedge clkcms);
		end
		if (pulses != exp_srst)
			flag_mismatch("l1a_srst_o cycles", exp_srst, pulses);
	endtask

	task automatic pulse_cal_line(int src, int line, int len, bit gated, int exp_lat,
		int exp_cnt);
		int    first = -1;
		int    highs = 0;
		logic  level;
		logic  prev  = 1'b0;
		string sname;
		sname = (line == 2) ? "pedestal_o" : (line == 1) ? "inject_o" : "pulse_o";
		for (int i = 0; i < len + 8; i++)
		begin
			@(negedge clkcms);
			level = (line == 2) ? pedestal_o : (line == 1) ? inject_o : pulse_o;
			if (level)
			begin
				if (first < 0)
					first = i;
				highs++;
			end
			if (gated && level && prev)
				note_failure("pulse_o high in two consecutive cycles with the gate on");
			prev = level;
			// CCB lines are active low, TTC codes are one strobe
			if (src == 0)
				ccb_cal_b_i[line] = (i < len) ? 1'b0 : 1'b1;
			else
			begin
				ccb_cmd_strb_i = (i == 0);
				ccb_cmd_i      = dmb_pkg::ccb_cmd_t'(int'(`DMB_CMD_TTC_CAL0) + line);
			end
		end
		ccb_cmd_strb_i = 1'b0;
		ccb_cal_b_i    = 3'b111;
		if (gated)
		begin
			if (highs < exp_cnt)
				note_failure("pulse_o never went high with the gate on");
		end
		else
		begin
			if (first != exp_lat)
				flag_mismatch({sname, " latency"}, exp_lat, first);
			if (highs != exp_cnt)
				flag_mismatch({sname, " cycles"}, exp_cnt, highs);
		end
	endtask

	task automatic replay_triggers(int n, int lat);
		logic [31:0] rnd;
		for (int i = 0; i < n + lat; i++)
		begin
			@(negedge clkcms);
			if (i >= lat)
			begin
				if (trg_enc_b0_o !== exp_b0[i-lat])
					flag_mismatch("trg_enc_b0_o", int'(exp_b0[i-lat]), int'(trg_enc_b0_o));
				if (trg_enc_b1_o !== exp_b1[i-lat])
					flag_mismatch("trg_enc_b1_o", int'(exp_b1[i-lat]), int'(trg_enc_b1_o));
				if (trg_enc_b2_o !== exp_b2[i-lat])
					flag_mismatch("trg_enc_b2_o", int'(exp_b2[i-lat]), int'(trg_enc_b2_o));
			end
			if (i < n)
			begin
				rnd         = $urandom;
				pre_lct_i   = rnd[4:0];
				l1a_match_i = rnd[9:5];
				l1a_cfeb_i  = rnd[10];
				// Bit 0 LCT, bit 1 match, bit 2 the L1A CFEB line in encode mode
				exp_b0[i] = rnd[4:0];
				exp_b1[i] = rnd[9:5];
				exp_b2[i] = enc_en_exp ? {`DMB_NCFEB{rnd[10]}} : '0;
			end
			else
			begin
				pre_lct_i   = '0;
				l1a_match_i = '0;
				l1a_cfeb_i  = 1'b0;
			end
		end
	endtask

	////////////////////////////////////////////////////////////
	// Interval timers
	////////////////////////////////////////////////////////////

	task automatic measure_interval(int sel, int n, int exp_t);
		int    waited = 0;
		int    got;
		string tname;
		tname = (sel != 0) ? "l1a_dav_time_o" : "lct_l1a_time_o";
		while (DUT.holdoff && waited < HOLDOFF_TIMEOUT)
		begin
			@(negedge clkcms);
			waited++;
		end
		if (DUT.holdoff)
			note_failure("holdoff still high, timer test started anyway");
		// Stop both timers, then clear the results
		@(negedge clkcms);
		l1acc_i = 1'b1;
		@(negedge clkcms);
		l1acc_i = 1'b0;
		dav_i   = 1'b1;
		@(negedge clkcms);
		dav_i     = 1'b0;
		tmr_clr_i = 1'b1;
		@(negedge clkcms);
		tmr_clr_i = 1'b0;
		@(negedge clkcms);
		if (lct_l1a_time_o !== '0)
			flag_mismatch("lct_l1a_time_o", 0, int'(lct_l1a_time_o));
		if (l1a_dav_time_o !== '0)
			flag_mismatch("l1a_dav_time_o", 0, int'(l1a_dav_time_o));
		for (int i = 0; i <= n; i++)
		begin
			if (sel == 0)
			begin
				pre_lct_i = (i == 0) ? dmb_pkg::cfeb_vec_t'(1) : '0;
				l1acc_i   = (i == n);
			end
			else
			begin
				l1acc_i = (i == 0);
				dav_i   = (i == n);
			end
			@(negedge clkcms);
		end
		pre_lct_i = '0;
		l1acc_i   = 1'b0;
		dav_i     = 1'b0;
		waited    = 0;
		got = (sel != 0) ? int'(l1a_dav_time_o) : int'(lct_l1a_time_o);
		while (got == 0 && waited < RESULT_TIMEOUT)
		begin
			@(negedge clkcms);
			got = (sel != 0) ? int'(l1a_dav_time_o) : int'(lct_l1a_time_o);
			waited++;
		end
		if (got == 0)
			note_failure({tname, " never changed after the stop strobe"});
		else if (got != exp_t)
			flag_mismatch(tname, exp_t, got);
	endtask

	initial
	begin
		logic [31:0] rec;
		int          nrec = 0;
		void'($urandom(89));
		clr0           = 1'b1;
		fpga_ready_i   = 1'b0;
		reset_i        = 1'b0;
		ccb_cmd_strb_i = 1'b0;
		ccb_cmd_i      = '0;
		ccb_data_i     = '0;
		ccb_cal_b_i    = 3'b111;
		pre_lct_i      = '0;
		l1a_match_i    = '0;
		l1a_cfeb_i     = 1'b0;
		l1acc_i        = 1'b0;
		dav_i          = 1'b0;
		tmr_clr_i      = 1'b0;
		enc_en_exp     = 1'b0;
		value_errs     = 0;
		other_errs     = 0;
		for (int i = 0; i < MAX_RECORDS; i++)
			vec_mem[i] = 32'h0;
		$readmemh("sim/dmb_vectors.txt", vec_mem);
		repeat (10) @(negedge clkcms);
		clr0 = 1'b0;
		repeat (2) @(negedge clkcms);
		if (ctrl_ready_o !== 1'b0)
			flag_mismatch("ctrl_ready_o", 0, int'(ctrl_ready_o));
		if (DUT.fpga_rst !== 1'b0)
			flag_mismatch("fpga_rst", 0, int'(DUT.fpga_rst));
		if (DUT.holdoff !== 1'b0)
			flag_mismatch("holdoff", 0, int'(DUT.holdoff));
		check_reset_sequence();
		while (nrec < MAX_RECORDS && vec_mem[nrec] != 32'h0 && vec_mem[nrec][31:28] != 4'hF)
		begin
			rec = vec_mem[nrec];
			case (rec[31:28])
				4'h1: send_command(int'(rec[25:20]), int'(rec[19:12]), int'(rec[11:0]));
				4'h2: pulse_cal_line(int'(rec[27:24]), int'(rec[21:20]), int'(rec[19:12]),
					1'b0, int'(rec[11:8]), int'(rec[7:0]));
				4'h3: replay_triggers(int'(rec[27:20]), int'(rec[11:8]));
				4'h4: measure_interval(int'(rec[20]), int'(rec[19:12]), int'(rec[11:0]));
				4'h5: pulse_cal_line(0, int'(rec[21:20]), int'(rec[19:12]), 1'b1, 0,
					int'(rec[7:0]));
				default: note_failure("unknown operation code in a vector record");
			endcase
			if (!ctrl_ready_o)
				note_failure("ctrl_ready_o dropped while fpga_ready_i was high");
			nrec++;
		end
		if (nrec == 0)
			note_failure("no records were read from sim/dmb_vectors.txt");
		// Ready must fall without waiting for a clock edge
		@(negedge clkcms);
		fpga_ready_i = 1'b0;
		#1;
		if (ctrl_ready_o !== 1'b0)
			flag_mismatch("ctrl_ready_o", 0, int'(ctrl_ready_o));
		$display("Records run: %0d, value errors: %0d, other failures: %0d",
			nrec, value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

// File: sim/dmb_vectors.txt
// One record per line, eight hex digits: op(1) a(2) b(2) expected(3)
// op 1 cmd a=code b=data exp=srst cycles, op 2 cal a=src/line b=len exp=lat/count
// op 3 trigger a=samples exp=latency<<8, op 4 timer a=sel b=N exp=time
// op 5 gated pulse b=len exp=min highs, op F ends the list
10300001 // L1A soft reset, one srst cycle
13000000 // config cleared
32800100 // trigger, 40 samples, latency 1
13001000 // encode_en
32800100 // trigger, latency 1
13003000 // encode_en and cable_dly
32800200 // trigger, latency 2
13002000 // cable_dly only
32800200 // trigger, latency 2
10300001 // soft reset clears config
32800100 // trigger, latency 1
12A00000 // unused code, no srst
20203103 // CCB pedestal 3 cycles, lat 1, 3 highs
20103203 // CCB inject 3 cycles, lat 2, 3 highs
20003204 // CCB pulse 3 cycles, lat 2, 4 highs
20001202 // CCB pulse 1 cycle, lat 2, 2 highs
21201201 // TTC pedestal, lat 2, 1 high
21101301 // TTC inject, lat 3, 1 high
21001302 // TTC pulse, lat 3, 2 highs
1300C000 // gate on
50006001 // gated pulse 6 cycles
50003001 // gated pulse 3 cycles
13000000 // gate off
20003204 // pulse shape back to normal
40005005 // LCT to L1A, 5
40014014 // LCT to L1A, 20
40064064 // LCT to L1A, 100
40107007 // L1A to DAV, 7
40128028 // L1A to DAV, 40
4013F03F // L1A to DAV, 63
4015003F // L1A to DAV, 80 saturates
401C803F // L1A to DAV, 200 saturates
F0000000

// File: tb.f
+incdir+src
src/dmb_pkg.sv
src/dmb_cfg_if.sv
src/ccb_cmd_dec.sv
src/reset_seq.sv
src/cal_pulse_cond.sv
src/trg_timer.sv
src/trg_enc_out.sv
src/dmb_trig_ctrl.sv
sim/tb_dmb_trig_ctrl.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_dmb_trig_ctrl
FLIST     ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
LINTFLAGS ?= --lint-only --timing --timescale 1ns/1ps
PASS_MSG  ?= Verification passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR)
